//--- design/alu_commit.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_commit (
  alu_result_if.snk                     i_result,

  // Commit channel
  output logic                          o_cmt_valid,
  input  logic                          i_cmt_ready,
  output logic [`ALU_PC_SIZE-1:0]       o_cmt_pc,
  output logic                          o_cmt_bjp,
  output logic                          o_cmt_bjp_prdt,
  output logic                          o_cmt_bjp_rslv,
  output logic                          o_cmt_ecall,
  output logic                          o_cmt_ebreak,
  output logic                          o_cmt_wfi,
  output logic                          o_cmt_ifu_ilegl,
  output logic                          o_cmt_ifu_buserr,
  output logic                          o_cmt_ifu_misalgn,

  // Write-back channel
  output logic                          o_wbck_valid,
  input  logic                          i_wbck_ready,
  output logic [`ALU_XLEN-1:0]          o_wbck_wdat,
  output logic [`ALU_RFIDX_WIDTH-1:0]   o_wbck_rdidx
);

  logic need_wbck;
  logic res_vld;

  assign res_vld = i_result.valid;

  ////////////////////
  // Handshake split

  // Errored ops never write the register file
  assign need_wbck = i_result.rdwen & ~i_result.err;

  // Each side waits on the other, so both complete in one cycle
  assign o_cmt_valid    = res_vld & (need_wbck ? i_wbck_ready : 1'b1);
  assign o_wbck_valid   = need_wbck & res_vld & i_cmt_ready;
  assign i_result.ready = i_cmt_ready & (need_wbck ? i_wbck_ready : 1'b1);

  assign o_wbck_wdat  = i_result.wdat;
  assign o_wbck_rdidx = i_result.rdidx;

  ////////////////////
  // Commit flags

  assign o_cmt_pc          = i_result.pc;
  assign o_cmt_bjp         = res_vld & i_result.bjp;
  assign o_cmt_bjp_prdt    = res_vld & i_result.prdt;
  assign o_cmt_bjp_rslv    = res_vld & i_result.rslv;
  assign o_cmt_ecall       = res_vld & i_result.ecall;
  assign o_cmt_ebreak      = res_vld & i_result.ebreak;
  assign o_cmt_wfi         = res_vld & i_result.wfi;
  assign o_cmt_ifu_ilegl   = res_vld & i_result.excp.ilegl;   // Also unknown groups
  assign o_cmt_ifu_buserr  = res_vld & i_result.excp.buserr;
  assign o_cmt_ifu_misalgn = res_vld & i_result.excp.misalgn;

endmodule

//--- design/alu_dispatch.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_dispatch (
  input  logic                          clk,
  input  logic                          i_rst_n,

  input  logic                          i_valid,
  output logic                          o_ready,
  input  logic [`ALU_XLEN-1:0]          i_rs1,
  input  logic [`ALU_XLEN-1:0]          i_rs2,
  input  logic [`ALU_XLEN-1:0]          i_imm,
  input  alu_pkg::dec_info_u            i_info,
  input  logic [`ALU_PC_SIZE-1:0]       i_pc,
  input  logic [`ALU_RFIDX_WIDTH-1:0]   i_rdidx,
  input  logic                          i_rdwen,
  input  logic                          i_ilegl,
  input  logic                          i_buserr,
  input  logic                          i_misalgn,

  alu_issue_if.src                      o_issue
);

  logic                  ifu_excp;
  logic                  alu_op;
  logic                  bjp_op;
  logic                  grp_unknown;
  alu_pkg::alu_excp_t    excp_nxt;
  logic [`ALU_XLEN-1:0]  op2_nxt;
  logic                  in_fire;
  logic                  uop_valid;

  ////////////////////
  // Classify

  // Fetch exceptions win over any decode group
  assign ifu_excp    = i_ilegl | i_buserr | i_misalgn;
  assign alu_op      = ~ifu_excp & (i_info.alu.grp == alu_pkg::GRP_ALU);
  assign bjp_op      = ~ifu_excp & (i_info.bjp.grp == alu_pkg::GRP_BJP);
  assign grp_unknown = ~ifu_excp & ~alu_op & ~bjp_op;

  assign excp_nxt.ilegl   = i_ilegl | grp_unknown;  // Unsupported group is illegal
  assign excp_nxt.buserr  = i_buserr;
  assign excp_nxt.misalgn = i_misalgn;

  // Branches always compare two registers
  assign op2_nxt = (alu_op & i_info.alu.op2imm) ? i_imm : i_rs2;

  ////////////////////
  // Pipeline register

  assign o_ready = ~uop_valid | o_issue.ready;  // Empty, or draining this cycle
  assign in_fire = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      uop_valid <= 1'b0;
    end else if (o_ready) begin
      uop_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      o_issue.info  <= i_info;
      o_issue.op1   <= i_rs1;
      o_issue.op2   <= op2_nxt;
      o_issue.rs2   <= i_rs2;
      o_issue.pc    <= i_pc;
      o_issue.rdidx <= i_rdidx;
      o_issue.rdwen <= i_rdwen;
      o_issue.excp  <= excp_nxt;
    end
  end

  assign o_issue.valid = uop_valid;

endmodule

//--- design/alu_dpath.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_dpath (
  input  logic       clk,
  input  logic       i_rst_n,
  alu_issue_if.snk   i_issue,
  alu_result_if.src  o_result
);

  localparam int XW      = `ALU_XLEN;
  localparam int SHAMT_W = $clog2(`ALU_XLEN);

  alu_pkg::alu_info_t       alu_info;
  alu_pkg::bjp_info_t       bjp_info;
  logic                     is_excp;
  logic                     is_alu;
  logic                     is_bjp;
  logic [XW-1:0]            op1;
  logic [XW-1:0]            opb;
  logic                     cmp_unsigned;
  logic                     add_sub;
  logic [XW:0]              add_a;
  logic [XW:0]              add_b;
  logic [XW:0]              add_res;
  logic                     lt;
  logic                     eq;
  logic [SHAMT_W-1:0]       shamt;
  logic [XW-1:0]            xor_res;
  logic [XW-1:0]            srl_res;
  logic [XW-1:0]            sra_res;
  logic [XW-1:0]            alu_res;
  logic                     cmp_res;
  logic                     rslv;
  logic [`ALU_PC_SIZE-1:0]  link_pc;
  logic [XW-1:0]            wdat_nxt;
  logic                     in_fire;
  logic                     res_valid;

  ////////////////////
  // Decode

  assign alu_info = i_issue.info.alu;
  assign bjp_info = i_issue.info.bjp;
  assign is_excp  = |i_issue.excp;
  assign is_alu   = ~is_excp & (alu_info.grp == alu_pkg::GRP_ALU);
  assign is_bjp   = ~is_excp & (bjp_info.grp == alu_pkg::GRP_BJP);

  assign op1 = i_issue.op1;
  assign opb = is_bjp ? i_issue.rs2 : i_issue.op2;

  ////////////////////
  // Shared datapath

  // One 33-bit adder, subtracting for sub, slt/sltu and every branch compare
  assign cmp_unsigned = is_bjp ? (bjp_info.bltu | bjp_info.bgeu) : alu_info.op_sltu;
  assign add_sub = is_bjp | alu_info.op_sub | alu_info.op_slt | alu_info.op_sltu;
  assign add_a   = {~cmp_unsigned & op1[XW-1], op1};
  assign add_b   = {~cmp_unsigned & opb[XW-1], opb};
  assign add_res = add_a + (add_sub ? ~add_b : add_b) + {{XW{1'b0}}, add_sub};
  assign lt      = add_res[XW];  // Sign of the extended difference

  assign xor_res = op1 ^ opb;
  assign eq      = ~|xor_res;  // Equality reuses the xor gates

  assign shamt   = opb[SHAMT_W-1:0];
  assign srl_res = op1 >> shamt;
  assign sra_res = srl_res | ({XW{op1[XW-1]}} & ~({XW{1'b1}} >> shamt));  // Sign fill

  assign alu_res = ({XW{alu_info.op_add | alu_info.op_sub}}  & add_res[XW-1:0])
                 | ({XW{alu_info.op_slt | alu_info.op_sltu}} & {{(XW-1){1'b0}}, lt})
                 | ({XW{alu_info.op_xor}} & xor_res)
                 | ({XW{alu_info.op_sll}} & (op1 << shamt))
                 | ({XW{alu_info.op_srl}} & srl_res)
                 | ({XW{alu_info.op_sra}} & sra_res)
                 | ({XW{alu_info.op_or}}  & (op1 | opb))
                 | ({XW{alu_info.op_and}} & (op1 & opb))
                 | ({XW{alu_info.op_lui}} & opb);

  ////////////////////
  // Branch resolve

  assign cmp_res = (bjp_info.beq & eq) | (bjp_info.bne & ~eq)
                 | ((bjp_info.blt | bjp_info.bltu) & lt)
                 | ((bjp_info.bge | bjp_info.bgeu) & ~lt);
  assign rslv    = bjp_info.jump | cmp_res;

  // Link is pc+4, or pc+2 for a compressed jump
  assign link_pc = i_issue.pc + {{(`ALU_PC_SIZE-3){1'b0}}, bjp_info.rv32, ~bjp_info.rv32, 1'b0};

  always_comb begin
    if (is_excp) begin
      wdat_nxt = '0;
    end else if (is_bjp) begin
      wdat_nxt = XW'(link_pc);
    end else begin
      wdat_nxt = alu_res;
    end
  end

  ////////////////////
  // Result register

  assign i_issue.ready = ~res_valid | o_result.ready;
  assign in_fire       = i_issue.valid & i_issue.ready;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      res_valid <= 1'b0;
    end else if (i_issue.ready) begin
      res_valid <= i_issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      o_result.wdat   <= wdat_nxt;
      o_result.err    <= is_excp;
      o_result.rdwen  <= i_issue.rdwen;
      o_result.rdidx  <= i_issue.rdidx;
      o_result.pc     <= i_issue.pc;
      o_result.excp   <= i_issue.excp;
      o_result.bjp    <= is_bjp;
      o_result.prdt   <= is_bjp & bjp_info.bprdt;
      o_result.rslv   <= is_bjp & rslv;
      o_result.ecall  <= is_alu & alu_info.ecall;
      o_result.ebreak <= is_alu & alu_info.ebreak;
      o_result.wfi    <= is_alu & alu_info.wfi;
    end
  end

  assign o_result.valid = res_valid;

endmodule

//--- design/alu_issue_if.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

// Micro-op from the dispatch register into the datapath
interface alu_issue_if;

  logic                         valid;
  logic                         ready;
  alu_pkg::dec_info_u           info;
  logic [`ALU_XLEN-1:0]         op1;
  logic [`ALU_XLEN-1:0]         op2;
  logic [`ALU_XLEN-1:0]         rs2;    // Raw rs2 for branch compares
  logic [`ALU_PC_SIZE-1:0]      pc;
  logic [`ALU_RFIDX_WIDTH-1:0]  rdidx;
  logic                         rdwen;
  alu_pkg::alu_excp_t           excp;

  modport src (
    output valid, info, op1, op2, rs2, pc, rdidx, rdwen, excp,
    input  ready
  );

  modport snk (
    input  valid, info, op1, op2, rs2, pc, rdidx, rdwen, excp,
    output ready
  );

endinterface

//--- design/alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

  // Decode groups known to this stage
  typedef enum logic [`ALU_GRP_WIDTH-1:0] {
    GRP_ALU = `ALU_GRP_ALU,
    GRP_BJP = `ALU_GRP_BJP
  } alu_grp_e;

  // Regular ALU view, first member is the top bit
  typedef struct packed {
    logic [`ALU_DECINFO_WIDTH-`ALU_GRP_WIDTH-17:0] pad;
    logic                       wfi;
    logic                       ebreak;
    logic                       ecall;
    logic                       op2imm;   // Operand 2 from immediate
    logic                       op_lui;
    logic                       op_sltu;
    logic                       op_slt;
    logic                       op_and;
    logic                       op_or;
    logic                       op_sra;
    logic                       op_srl;
    logic                       op_sll;
    logic                       op_xor;
    logic                       op_sub;
    logic                       op_add;
    logic                       rv32;
    logic [`ALU_GRP_WIDTH-1:0]  grp;
  } alu_info_t;

  // Branch and jump view of the same word
  typedef struct packed {
    logic [`ALU_DECINFO_WIDTH-`ALU_GRP_WIDTH-10:0] pad;
    logic                       bgeu;
    logic                       bltu;
    logic                       bge;
    logic                       blt;
    logic                       bne;
    logic                       beq;
    logic                       bprdt;    // Predicted taken
    logic                       jump;
    logic                       rv32;
    logic [`ALU_GRP_WIDTH-1:0]  grp;
  } bjp_info_t;

  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } dec_info_u;

  typedef struct packed {
    logic ilegl;
    logic buserr;
    logic misalgn;
  } alu_excp_t;

endpackage

//--- design/alu_result_if.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

// Registered result from the datapath into the commit split
interface alu_result_if;

  logic                         valid;
  logic                         ready;
  logic [`ALU_XLEN-1:0]         wdat;
  logic                         err;
  logic                         rdwen;
  logic [`ALU_RFIDX_WIDTH-1:0]  rdidx;
  logic [`ALU_PC_SIZE-1:0]      pc;
  alu_pkg::alu_excp_t           excp;
  logic                         bjp;
  logic                         prdt;
  logic                         rslv;
  logic                         ecall;
  logic                         ebreak;
  logic                         wfi;

  modport src (
    output valid, wdat, err, rdwen, rdidx, pc, excp, bjp, prdt, rslv, ecall, ebreak, wfi,
    input  ready
  );

  modport snk (
    input  valid, wdat, err, rdwen, rdidx, pc, excp, bjp, prdt, rslv, ecall, ebreak, wfi,
    output ready
  );

endinterface

//--- design/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

////////////////////
// Datapath widths

`define ALU_XLEN           32
`define ALU_PC_SIZE        32
`define ALU_RFIDX_WIDTH    5

////////////////////
// Decode info word

`define ALU_DECINFO_WIDTH  20
`define ALU_GRP_WIDTH      3   // Low bits of the info word

// Group codes, every other code is illegal here
`define ALU_GRP_ALU        0
`define ALU_GRP_BJP        1

`endif

//--- design/alu_top.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_top (
  input  logic                          clk,
  input  logic                          i_rst_n,

  // Decoded instruction in
  input  logic                          i_valid,
  output logic                          o_ready,
  input  logic [`ALU_XLEN-1:0]          i_rs1,
  input  logic [`ALU_XLEN-1:0]          i_rs2,
  input  logic [`ALU_XLEN-1:0]          i_imm,
  input  logic [`ALU_DECINFO_WIDTH-1:0] i_info,
  input  logic [`ALU_PC_SIZE-1:0]       i_pc,
  input  logic [`ALU_RFIDX_WIDTH-1:0]   i_rdidx,
  input  logic                          i_rdwen,
  input  logic                          i_ilegl,
  input  logic                          i_buserr,
  input  logic                          i_misalgn,

  // Commit out
  output logic                          o_cmt_valid,
  input  logic                          i_cmt_ready,
  output logic [`ALU_PC_SIZE-1:0]       o_cmt_pc,
  output logic                          o_cmt_bjp,
  output logic                          o_cmt_bjp_prdt,
  output logic                          o_cmt_bjp_rslv,
  output logic                          o_cmt_ecall,
  output logic                          o_cmt_ebreak,
  output logic                          o_cmt_wfi,
  output logic                          o_cmt_ifu_ilegl,
  output logic                          o_cmt_ifu_buserr,
  output logic                          o_cmt_ifu_misalgn,

  // Write-back out
  output logic                          o_wbck_valid,
  input  logic                          i_wbck_ready,
  output logic [`ALU_XLEN-1:0]          o_wbck_wdat,
  output logic [`ALU_RFIDX_WIDTH-1:0]   o_wbck_rdidx
);

  alu_issue_if  u_issue_if ();
  alu_result_if u_result_if ();

  ////////////////////
  // Stage 1 and 2

  alu_dispatch u_dispatch (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_valid),
    .o_ready   (o_ready),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_imm     (i_imm),
    .i_info    (alu_pkg::dec_info_u'(i_info)),
    .i_pc      (i_pc),
    .i_rdidx   (i_rdidx),
    .i_rdwen   (i_rdwen),
    .i_ilegl   (i_ilegl),
    .i_buserr  (i_buserr),
    .i_misalgn (i_misalgn),
    .o_issue   (u_issue_if)
  );

  alu_dpath u_dpath (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_issue  (u_issue_if),
    .o_result (u_result_if)
  );

  ////////////////////
  // Stage 3, combinational

  alu_commit u_commit (
    .i_result          (u_result_if),
    .o_cmt_valid       (o_cmt_valid),
    .i_cmt_ready       (i_cmt_ready),
    .o_cmt_pc          (o_cmt_pc),
    .o_cmt_bjp         (o_cmt_bjp),
    .o_cmt_bjp_prdt    (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv    (o_cmt_bjp_rslv),
    .o_cmt_ecall       (o_cmt_ecall),
    .o_cmt_ebreak      (o_cmt_ebreak),
    .o_cmt_wfi         (o_cmt_wfi),
    .o_cmt_ifu_ilegl   (o_cmt_ifu_ilegl),
    .o_cmt_ifu_buserr  (o_cmt_ifu_buserr),
    .o_cmt_ifu_misalgn (o_cmt_ifu_misalgn),
    .o_wbck_valid      (o_wbck_valid),
    .i_wbck_ready      (i_wbck_ready),
    .o_wbck_wdat       (o_wbck_wdat),
    .o_wbck_rdidx      (o_wbck_rdidx)
  );

endmodule

//--- list.f
+incdir+design
design/alu_pkg.sv
design/alu_issue_if.sv
design/alu_result_if.sv
design/alu_dispatch.sv
design/alu_dpath.sv
design/alu_commit.sv
design/alu_top.sv
test/alu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f list.f \
  --top-module alu_tb -Mdir obj_dir -o alu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/alu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^ALL TESTS PASSED$'; then
  exit 0
fi
exit 1

//--- test/alu_tb.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_tb;

  localparam int FIELDS  = 11;  // Words per vector in the data file
  localparam int MAX_VEC = 64;

  logic                          clk;
  logic                          i_rst_n;
  logic                          i_valid;
  logic                          o_ready;
  logic [`ALU_XLEN-1:0]          i_rs1;
  logic [`ALU_XLEN-1:0]          i_rs2;
  logic [`ALU_XLEN-1:0]          i_imm;
  logic [`ALU_DECINFO_WIDTH-1:0] i_info;
  logic [`ALU_PC_SIZE-1:0]       i_pc;
  logic [`ALU_RFIDX_WIDTH-1:0]   i_rdidx;
  logic                          i_rdwen;
  logic                          i_ilegl;
  logic                          i_buserr;
  logic                          i_misalgn;
  logic                          o_cmt_valid;
  logic                          i_cmt_ready;
  logic [`ALU_PC_SIZE-1:0]       o_cmt_pc;
  logic                          o_cmt_bjp;
  logic                          o_cmt_bjp_prdt;
  logic                          o_cmt_bjp_rslv;
  logic                          o_cmt_ecall;
  logic                          o_cmt_ebreak;
  logic                          o_cmt_wfi;
  logic                          o_cmt_ifu_ilegl;
  logic                          o_cmt_ifu_buserr;
  logic                          o_cmt_ifu_misalgn;
  logic                          o_wbck_valid;
  logic                          i_wbck_ready;
  logic [`ALU_XLEN-1:0]          o_wbck_wdat;
  logic [`ALU_RFIDX_WIDTH-1:0]   o_wbck_rdidx;

  logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
  int          n_vec;
  int          exp_q[$];  // Indices of vectors in flight, oldest first
  int          cycle = 0;
  int          t_in;
  int          t_cmt;
  int          cmt_count;
  int          cmt_idx;
  int          pass_cnt;
  int          fail_cnt;
  int          err_cnt;
  int          proto_err;
  logic        loaded;
  logic        rand_mode;
  logic [15:0] lfsr = 16'd51;

  alu_top uut (
    .clk (clk), .i_rst_n (i_rst_n),
    .i_valid (i_valid), .o_ready (o_ready),
    .i_rs1 (i_rs1), .i_rs2 (i_rs2), .i_imm (i_imm), .i_info (i_info), .i_pc (i_pc),
    .i_rdidx (i_rdidx), .i_rdwen (i_rdwen),
    .i_ilegl (i_ilegl), .i_buserr (i_buserr), .i_misalgn (i_misalgn),
    .o_cmt_valid (o_cmt_valid), .i_cmt_ready (i_cmt_ready), .o_cmt_pc (o_cmt_pc),
    .o_cmt_bjp (o_cmt_bjp), .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_cmt_ecall (o_cmt_ecall), .o_cmt_ebreak (o_cmt_ebreak), .o_cmt_wfi (o_cmt_wfi),
    .o_cmt_ifu_ilegl (o_cmt_ifu_ilegl), .o_cmt_ifu_buserr (o_cmt_ifu_buserr),
    .o_cmt_ifu_misalgn (o_cmt_ifu_misalgn),
    .o_wbck_valid (o_wbck_valid), .i_wbck_ready (i_wbck_ready),
    .o_wbck_wdat (o_wbck_wdat), .o_wbck_rdidx (o_wbck_rdidx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input logic ok);
    if (ok) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: mismatch", name);
    end
  endtask

  ////////////////////
  // Driver

  task automatic send_vector(input int idx);
    int b;
    b = idx * FIELDS;
    @(negedge clk);
    i_info    = vec_mem[b][`ALU_DECINFO_WIDTH-1:0];
    i_rs1     = vec_mem[b+1];
    i_rs2     = vec_mem[b+2];
    i_imm     = vec_mem[b+3];
    i_pc      = vec_mem[b+4];
    i_rdidx   = vec_mem[b+5][`ALU_RFIDX_WIDTH-1:0];
    i_rdwen   = vec_mem[b+6][0];
    i_ilegl   = vec_mem[b+7][2];
    i_buserr  = vec_mem[b+7][1];
    i_misalgn = vec_mem[b+7][0];
    i_valid   = 1'b1;
    @(posedge clk);
    while (!o_ready) @(posedge clk);
    exp_q.push_back(idx);
    t_in = cycle;
  endtask

  // Ready pattern for the commit and write-back channels
  always @(negedge clk) begin
    if (rand_mode) begin
      lfsr = lfsr_next(lfsr);
      i_cmt_ready = lfsr[0];
      lfsr = lfsr_next(lfsr);
      i_wbck_ready = lfsr[0];
    end else begin
      i_cmt_ready  = 1'b1;
      i_wbck_ready = 1'b1;
    end
  end

  ////////////////////
  // Checker

  task automatic check_commit(input int idx);
    int         b;
    int         errs;
    logic [8:0] got_flags;
    logic [8:0] exp_flags;
    logic       need;
    b = idx * FIELDS;
    errs = 0;
    exp_flags = vec_mem[b+9][8:0];
    need = vec_mem[b+10][0];
    got_flags = {o_cmt_ifu_misalgn, o_cmt_ifu_buserr, o_cmt_ifu_ilegl, o_cmt_wfi,
                 o_cmt_ebreak, o_cmt_ecall, o_cmt_bjp_rslv, o_cmt_bjp_prdt, o_cmt_bjp};
    if (got_flags !== exp_flags) begin
      report_fail($sformatf("vector %0d flags %h, expected %h", idx, got_flags, exp_flags));
      errs++;
    end
    if (o_cmt_pc !== vec_mem[b+4]) begin
      report_fail($sformatf("vector %0d pc %h, expected %h", idx, o_cmt_pc, vec_mem[b+4]));
      errs++;
    end
    if ((o_wbck_valid & i_wbck_ready) !== need) begin
      report_fail($sformatf("vector %0d write-back %b, expected %b", idx,
                            o_wbck_valid & i_wbck_ready, need));
      errs++;
    end
    if (need && o_wbck_wdat !== vec_mem[b+8]) begin
      report_fail($sformatf("vector %0d wdat %h, expected %h", idx, o_wbck_wdat,
                            vec_mem[b+8]));
      errs++;
    end
    if (need && o_wbck_rdidx !== vec_mem[b+5][`ALU_RFIDX_WIDTH-1:0]) begin
      report_fail($sformatf("vector %0d rdidx %h, expected %h", idx, o_wbck_rdidx,
                            vec_mem[b+5][`ALU_RFIDX_WIDTH-1:0]));
      errs++;
    end
    finish_test($sformatf("vector %0d", idx), errs == 0);
  endtask

  always @(posedge clk) begin
    if (i_rst_n) begin
      if (o_wbck_valid && !i_cmt_ready) begin
        $display("Write-back valid was high without commit ready at %0t ns", $time);
        proto_err++;
        err_cnt++;
      end
      if (o_wbck_valid && i_wbck_ready && !(o_cmt_valid && i_cmt_ready)) begin
        $display("A write-back completed without its commit at %0t ns", $time);
        proto_err++;
        err_cnt++;
      end
      if (o_cmt_valid && i_cmt_ready) begin
        if (cmt_count == 0) t_cmt = cycle;
        cmt_count++;
        if (exp_q.size() == 0) begin
          $display("A commit at %0t ns had no instruction waiting for it", $time);
          proto_err++;
          err_cnt++;
        end else begin
          cmt_idx = exp_q.pop_front();
          check_commit(cmt_idx);
        end
      end
    end
  end

  ////////////////////
  // Sequence

  initial begin
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_imm = '0;
    i_info = '0;
    i_pc = '0;
    i_rdidx = '0;
    i_rdwen = 1'b0;
    i_ilegl = 1'b0;
    i_buserr = 1'b0;
    i_misalgn = 1'b0;
    i_cmt_ready = 1'b1;
    i_wbck_ready = 1'b1;
    rand_mode = 1'b0;
    loaded = 1'b0;
    cmt_count = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    err_cnt = 0;
    proto_err = 0;
    $readmemh("test/alu_testdata.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS] !== 32'hffffffff) n_vec++;
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    if (o_cmt_valid !== 1'b0 || o_wbck_valid !== 1'b0 || o_ready !== 1'b1) begin
      report_fail("outputs after reset are not idle");
      finish_test("reset", 1'b0);
    end else begin
      finish_test("reset", 1'b1);
    end

    if (n_vec == 0) begin
      $display("No vectors were found in the test data file");
      err_cnt++;
    end else begin
      // First vector alone, both readies high
      send_vector(0);
      @(negedge clk);
      i_valid = 1'b0;
      while (cmt_count < 1) @(negedge clk);
      if (t_cmt - t_in != 2) begin
        report_fail($sformatf("commit came %0d cycles after input", t_cmt - t_in));
      end
      finish_test("latency", t_cmt - t_in == 2);

      @(posedge clk);
      rand_mode = 1'b1;
      for (int i = 1; i < n_vec; i++) send_vector(i);
      @(negedge clk);
      i_valid = 1'b0;
      while (cmt_count < n_vec) @(negedge clk);
      @(posedge clk);
      rand_mode = 1'b0;
      repeat (6) @(negedge clk);
      finish_test("order", cmt_count == n_vec && exp_q.size() == 0 && proto_err == 0);
    end

    $display("%0d tests passed, %0d tests failed, %0d failed checks",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Ten cycles per vector plus some slack
  initial begin
    wait (loaded);
    repeat ((n_vec + 20) * 10) @(posedge clk);
    $display("The run timed out before every vector had committed");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- test/alu_testdata.txt
// info rs1 rs2 imm pc rdidx rdwen excp(ilegl buserr misalgn) wdat flags need_wbck
// flags bits 0 to 8 are bjp prdt rslv ecall ebreak wfi ilegl buserr misalgn
00018 00000005 00000003 00000000 00001000 01 1 0 00000008 000 1  // add
08018 7fffffff 12345678 00000001 00001004 02 1 0 80000000 000 1  // addi overflow
08018 00000010 00000000 fffffff0 00001008 03 1 0 00000000 000 1  // addi negative
00028 00000003 00000005 00000000 0000100c 04 1 0 fffffffe 000 1  // sub
01008 ffffffff 00000001 00000000 00001010 06 1 0 00000001 000 1  // slt
01008 7fffffff 80000000 00000000 00001014 07 1 0 00000000 000 1  // slt
02008 ffffffff 00000001 00000000 00001018 08 1 0 00000000 000 1  // sltu
0a008 00000001 00000000 ffffffff 0000101c 09 1 0 00000001 000 1  // sltiu
0c008 12345678 00000000 abcde000 00001020 0a 1 0 abcde000 000 1  // lui
00048 ff00ff00 0f0f0f0f 00000000 00001024 0b 1 0 f00ff00f 000 1  // xor
08408 00f0000f 00000000 0000f0f0 00001028 0c 1 0 00f0f0ff 000 1  // ori
00808 ff00ff00 0f0f0f0f 00000000 0000102c 0d 1 0 0f000f00 000 1  // and
00088 00000001 0000001f 00000000 00001030 0e 1 0 80000000 000 1  // sll
08088 12345678 00000000 00000024 00001034 0f 1 0 23456780 000 1  // slli, upper bits ignored
00108 80000000 00000004 00000000 00001038 10 1 0 08000000 000 1  // srl
00208 80000000 00000004 00000000 0000103c 11 1 0 f8000000 000 1  // sra negative
08208 7f00ff00 00000000 00000008 00001040 12 1 0 007f00ff 000 1  // srai positive
00208 c0000000 0000001f 00000000 00001044 13 1 0 ffffffff 000 1  // sra by 31
10008 00000000 00000000 00000000 00001048 00 0 0 00000000 008 0  // ecall
20008 00000000 00000000 00000000 0000104c 00 0 0 00000000 010 0  // ebreak
40008 00000000 00000000 00000000 00001050 00 0 0 00000000 020 0  // wfi
00049 00000005 00000005 00000000 00001054 00 0 0 00000000 005 0  // beq taken
00069 00000005 00000006 00000000 00001058 00 0 0 00000000 003 0  // beq not taken, predicted
00089 00000001 00000002 00000000 0000105c 00 0 0 00000000 005 0  // bne taken
00109 ffffffff 00000001 00000000 00001060 00 0 0 00000000 005 0  // blt taken
00209 80000000 7fffffff 00000000 00001064 00 0 0 00000000 001 0  // bge not taken
00409 ffffffff 00000001 00000000 00001068 00 0 0 00000000 001 0  // bltu not taken
00829 ffffffff 00000001 00000000 0000106c 00 0 0 00000000 007 0  // bgeu taken, predicted
00019 00000000 00000000 00000000 00001070 01 1 0 00001074 005 1  // jal
00031 00000000 00000000 00000000 00001074 01 1 0 00001076 007 1  // compressed jal
00018 00000001 00000001 00000000 00001078 05 1 4 00000000 040 0  // fetch illegal
00018 00000001 00000001 00000000 0000107c 05 1 2 00000000 080 0  // fetch bus error
00018 00000001 00000001 00000000 00001080 05 1 1 00000000 100 0  // fetch misaligned
00012 00000001 00000001 00000000 00001084 05 1 0 00000000 040 0  // group 2
1000f 00000001 00000001 00000000 00001088 05 1 0 00000000 040 0  // group 7 with ecall bit
00018 00000001 00000001 00000000 0000108c 05 0 0 00000002 000 0  // add, no write-back
00018 ffffffff 00000001 00000000 00001090 1f 1 0 00000000 000 1  // add wraps
ffffffff  // End of vectors
